// File: compile.f
+incdir+include
hdl/esp_cmd_pkg.sv
hdl/trs_bus_pkg.sv
hdl/edge_sync.sv
hdl/spi_slave.sv
hdl/cmd_parser.sv
hdl/esp_registers.sv
hdl/port_decoder.sv
hdl/esp_handshake.sv
hdl/trs_io_top.sv
test/trs_io_assert.sv
test/tb_trs_io.sv

// File: hdl/cmd_parser.sv
`timescale 1ns/1ns

module cmd_parser import esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output esp_cmd_t   cmd,
  output logic       cmd_valid
);

  typedef enum logic {
    st_idle,
    st_params
  } state_t;

  state_t     state;
  logic [1:0] remaining;  // parameter bytes still expected
  cmd_code_t  rx_code;
  logic [1:0] rx_params;

  // only the codes this card implements
  function automatic logic known_code(logic [7:0] code);
    case (code)
      cmd_get_cookie,
      cmd_dbus_read,
      cmd_dbus_write,
      cmd_data_ready,
      cmd_get_version,
      cmd_abus_read,
      cmd_set_led,
      cmd_get_config: known_code = 1'b1;
      default:        known_code = 1'b0;
    endcase
  endfunction

  assign rx_code   = cmd_code_t'(rx_byte);
  assign rx_params = param_count(rx_code);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      remaining <= 2'd0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          st_idle: begin
            // unknown codes are dropped silently
            if (known_code(rx_byte)) begin
              cmd.code  <= rx_code;
              remaining <= rx_params;
              if (rx_params == 2'd0)
                cmd_valid <= 1'b1;
              else
                state <= st_params;
            end
          end
          st_params: begin
            cmd.param <= rx_byte;
            remaining <= remaining - 2'd1;
            if (remaining == 2'd1) begin
              cmd_valid <= 1'b1;  // last parameter in
              state     <= st_idle;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

// File: hdl/edge_sync.sv
`timescale 1ns/1ns

module edge_sync #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  T     in,
  output T     level,
  output T     rise,
  output T     fall
);

  localparam int W = $bits(T);

  logic [W-1:0] s1, s2, s3;  // s1/s2 synchronizer, s3 previous value

  always_ff @(posedge clk) begin
    if (rst) begin
      s1 <= '0;
      s2 <= '0;
      s3 <= '0;
    end else begin
      s1 <= in;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign level = T'(s2);
  assign rise  = T'(s2 & ~s3);
  assign fall  = T'(~s2 & s3);

endmodule

// File: hdl/esp_cmd_pkg.sv
package esp_cmd_pkg;

  // commands the ESP sends over SPI
  typedef enum logic [7:0] {
    cmd_get_cookie  = 8'd0,
    cmd_dbus_read   = 8'd3,
    cmd_dbus_write  = 8'd4,
    cmd_data_ready  = 8'd5,
    cmd_get_version = 8'd15,
    cmd_abus_read   = 8'd18,
    cmd_set_led     = 8'd26,
    cmd_get_config  = 8'd27
  } cmd_code_t;

  // a complete command as handed to the register block
  typedef struct packed {
    cmd_code_t  code;
    logic [7:0] param;  // only valid for commands with a parameter
  } esp_cmd_t;

  // number of parameter bytes following the command byte
  function automatic logic [1:0] param_count(cmd_code_t code);
    case (code)
      cmd_dbus_write,
      cmd_set_led: param_count = 2'd1;
      default:     param_count = 2'd0;
    endcase
  endfunction

endpackage

// File: hdl/esp_handshake.sv
`timescale 1ns/1ns

`include "trs_io_params.svh"

module esp_handshake (
  input  logic clk,
  input  logic rst,
  input  logic esp_start,
  input  logic done_rise,
  output logic req,
  output logic bus_wait   // holds the Z80 until the ESP is done
);

  logic [5:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      req      <= 1'b0;
      bus_wait <= 1'b0;
      hold_cnt <= 6'd0;
    end else if (esp_start) begin
      req      <= 1'b1;
      bus_wait <= 1'b1;
      hold_cnt <= `REQ_HOLD_CYCLES;
    end else if (done_rise) begin
      // ESP may answer before the pulse ends, drop both
      req      <= 1'b0;
      bus_wait <= 1'b0;
      hold_cnt <= 6'd0;
    end else if (hold_cnt != 6'd0) begin
      hold_cnt <= hold_cnt - 6'd1;
      if (hold_cnt == 6'd1)
        req <= 1'b0;  // end of request pulse
    end
  end

endmodule

// File: hdl/esp_registers.sv
`timescale 1ns/1ns

`include "trs_io_params.svh"

module esp_registers import esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  esp_cmd_t   cmd,
  input  logic       cmd_valid,
  input  logic [7:0] d_in,
  input  logic [7:0] a,
  input  logic [3:0] conf,
  input  logic       trs_io_hit,
  output logic [7:0] tx_byte,
  output logic [7:0] trs_data,
  output logic [2:0] led,
  output logic       int_req
);

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_byte  <= 8'h00;
      trs_data <= 8'h00;
      led      <= 3'b000;
      int_req  <= 1'b0;
    end else begin
      // Z80 touched port 1fh, it has seen the data
      if (trs_io_hit)
        int_req <= 1'b0;

      if (cmd_valid) begin
        case (cmd.code)
          cmd_get_cookie:  tx_byte <= `TRS_COOKIE;
          cmd_get_version: tx_byte <= {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
          cmd_dbus_read:   tx_byte <= d_in;      // bus snapshot
          cmd_abus_read:   tx_byte <= a;
          cmd_get_config:  tx_byte <= {4'b0000, conf};
          cmd_dbus_write:  trs_data <= cmd.param;
          cmd_set_led:     led <= cmd.param[2:0];
          cmd_data_ready:  int_req <= 1'b1;      // wins over a same-cycle clear
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/port_decoder.sv
`timescale 1ns/1ns

`include "trs_io_params.svh"

module port_decoder import trs_bus_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic [7:0]   a,
  input  logic         in_n,
  input  logic         out_n,
  input  logic         ioreq_n,
  input  logic [7:0]   d_in,
  input  logic [7:0]   trs_data,
  input  logic         access_rise,  // filtered edge of access_raw
  output logic         access_raw,
  output logic         esp_start,
  output esp_service_t service,
  output logic         trs_io_hit,
  output logic [7:0]   d_out,
  output logic         drive_en,
  output logic         dir,
  output logic         esp_sel_in,
  output logic [1:0]   cass
);

  logic io_in, io_out;  // active high, qualified with ioreq
  logic trs_io_sel, frehd_sel, cass_sel;
  logic esp_sel_out;

  assign io_in      = ~in_n & ~ioreq_n;
  assign io_out     = ~out_n & ~ioreq_n;
  assign access_raw = io_in | io_out;

  assign trs_io_sel = (a == `PORT_TRS_IO);
  assign frehd_sel  = (a[7:4] == `PORT_FREHD_HI);
  assign cass_sel   = (a == `PORT_CASS);

  assign esp_sel_in  = (trs_io_sel | frehd_sel) & io_in;
  assign esp_sel_out = (trs_io_sel | frehd_sel) & io_out;
  assign esp_start   = access_rise & (esp_sel_in | esp_sel_out);
  assign trs_io_hit  = access_rise & trs_io_sel & access_raw;

  always_comb begin
    if (frehd_sel)
      service = io_out ? svc_frehd_out : svc_frehd_in;
    else
      service = io_out ? svc_trs_io_out : svc_trs_io_in;
  end

  // card only drives the bus on its own IN ports
  assign drive_en = esp_sel_in;
  assign dir      = io_in;  // high = towards the Z80
  assign d_out    = drive_en ? trs_data : 8'h00;

  always_ff @(posedge clk) begin
    if (rst)
      cass <= 2'b00;
    else if (access_rise && cass_sel && io_out)
      cass <= d_in[1:0];
  end

endmodule

// File: hdl/spi_slave.sv
`timescale 1ns/1ns

module spi_slave import trs_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  spi_pins_t  pins,       // synchronized levels
  input  spi_pins_t  pins_rise,
  input  spi_pins_t  pins_fall,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       miso
);

  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  assign cs_active = ~pins.cs_n;

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
      tx_shift <= 8'h00;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;  // realign on every frame
      end else begin
        if (pins_rise.sck) begin
          bit_cnt  <= bit_cnt + 3'd1;
          rx_shift <= {rx_shift[6:0], pins.mosi};  // msb first
          if (bit_cnt == 3'd7)
            rx_valid <= 1'b1;
        end
        if (pins_fall.sck) begin
          if (bit_cnt == 3'd1)
            tx_shift <= tx_byte;  // reply from the previous command
          else
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active ? tx_shift[7] : 1'b0;

endmodule

// File: hdl/trs_bus_pkg.sv
package trs_bus_pkg;

  // SPI pins from the ESP, sampled together
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // strobes that need filtering and edge detection
  typedef struct packed {
    logic io_access;  // any qualified IN or OUT cycle
    logic esp_done;   // ESP finished servicing
  } bus_strobe_t;

  // service code presented to the ESP on esp_s
  typedef enum logic [3:0] {
    svc_trs_io_in  = 4'd0,
    svc_trs_io_out = 4'd1,
    svc_frehd_in   = 4'd2,
    svc_frehd_out  = 4'd3
  } esp_service_t;

endpackage

// File: hdl/trs_io_top.sv
`timescale 1ns/1ns

module trs_io_top import trs_bus_pkg::*, esp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  input  logic [7:0] a,
  input  logic [7:0] d_in,
  output logic [7:0] d_out,
  output logic       drive_en,
  output logic       dir,
  input  logic       in_n,
  input  logic       out_n,
  input  logic       ioreq_n,
  input  logic       done,
  output logic       req,
  output logic       bus_wait,
  output logic [3:0] esp_s,
  output logic       esp_sel_in,
  output logic       int_req,
  output logic [2:0] led,
  input  logic [3:0] conf,
  output logic [1:0] cass
);

  spi_pins_t    spi_raw, spi_level, spi_rise, spi_fall;
  bus_strobe_t  bus_raw, bus_rise;
  logic         access_raw;
  logic [7:0]   rx_byte, tx_byte, trs_data;
  logic         rx_valid, cmd_valid, esp_start, trs_io_hit;
  esp_cmd_t     cmd;
  esp_service_t service;

  assign spi_raw = '{sck: sck, cs_n: cs_n, mosi: mosi};
  assign bus_raw = '{io_access: access_raw, esp_done: done};
  assign esp_s   = service;

  edge_sync #(.T(spi_pins_t)) i_spi_sync (
    .clk(clk), .rst(rst), .in(spi_raw), .level(spi_level), .rise(spi_rise), .fall(spi_fall)
  );

  // bus levels are not needed, only the edges
  edge_sync #(.T(bus_strobe_t)) i_bus_sync (
    .clk(clk), .rst(rst), .in(bus_raw), .level(), .rise(bus_rise), .fall()
  );

  spi_slave i_spi_slave (
    .clk(clk), .rst(rst), .pins(spi_level), .pins_rise(spi_rise), .pins_fall(spi_fall),
    .tx_byte(tx_byte), .rx_byte(rx_byte), .rx_valid(rx_valid), .miso(miso)
  );

  cmd_parser i_cmd_parser (
    .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .cmd(cmd), .cmd_valid(cmd_valid)
  );

  esp_registers i_esp_registers (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .d_in(d_in), .a(a),
    .conf(conf), .trs_io_hit(trs_io_hit), .tx_byte(tx_byte), .trs_data(trs_data),
    .led(led), .int_req(int_req)
  );

  port_decoder i_port_decoder (
    .clk(clk), .rst(rst), .a(a), .in_n(in_n), .out_n(out_n), .ioreq_n(ioreq_n),
    .d_in(d_in), .trs_data(trs_data), .access_rise(bus_rise.io_access),
    .access_raw(access_raw), .esp_start(esp_start), .service(service),
    .trs_io_hit(trs_io_hit), .d_out(d_out), .drive_en(drive_en), .dir(dir),
    .esp_sel_in(esp_sel_in), .cass(cass)
  );

  esp_handshake i_esp_handshake (
    .clk(clk), .rst(rst), .esp_start(esp_start), .done_rise(bus_rise.esp_done),
    .req(req), .bus_wait(bus_wait)
  );

endmodule

// File: include/trs_io_params.svh
`ifndef TRS_IO_PARAMS_SVH
`define TRS_IO_PARAMS_SVH

// magic byte the ESP reads back to find the card
`define TRS_COOKIE 8'haf

// version byte is {major, minor}
`define TRS_VERSION_MAJOR 3'd0
`define TRS_VERSION_MINOR 5'd3

// clk cycles the request line to the ESP stays high
`define REQ_HOLD_CYCLES 6'd50

// Z80 I/O port map (Model III)
`define PORT_TRS_IO 8'h1f   // trs-io data port
`define PORT_FREHD_HI 4'hc  // frehd covers c0h-cfh
`define PORT_CASS 8'hff     // cassette output latch

`endif

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_trs_io -Mdir obj_dir -f compile.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_trs_io 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
printf '%s\n' "$out" | grep -qx "Test passed" || exit 1
exit 0

// File: test/tb_trs_io.sv
`timescale 1ns/1ns

`include "trs_io_params.svh"

module tb_trs_io import esp_cmd_pkg::*, trs_bus_pkg::*; ();

  localparam int max_cycles = 20000;  // full run needs roughly 4400

  logic       clk = 1'b0;
  logic       rst, sck, cs_n, mosi, miso;
  logic [7:0] a, d_in, d_out;
  logic       drive_en, dir, in_n, out_n, ioreq_n;
  logic       done, req, bus_wait, esp_sel_in, int_req;
  logic [3:0] esp_s, conf;
  logic [2:0] led;
  logic [1:0] cass;
  integer     seed = 53129;
  int         cycle_cnt = 0;
  logic [7:0] trs_data_m;  // reference model of the card state
  logic [2:0] led_m;
  logic       int_req_m;
  logic [1:0] cass_m;

  trs_io_top i_trs_io_top (.*);

  bind trs_io_top trs_io_assert i_trs_io_assert (
    .clk(clk), .rst(rst), .req(req), .bus_wait(bus_wait),
    .done_rise(bus_rise.esp_done), .cmd_valid(cmd_valid)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("timeout: the tests did not finish within %0d clock cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;  // inputs change just after the edge
  endtask

  task automatic random_byte(output logic [7:0] val);
    integer r;
    r = $random(seed);
    val = r[7:0];
  endtask

  // the two port ranges served by the ESP
  function automatic logic esp_port(input logic [7:0] port);
    return port == `PORT_TRS_IO || port[7:4] == `PORT_FREHD_HI;
  endfunction

  function automatic logic [3:0] service_for(input logic [7:0] port, input logic is_out);
    if (port[7:4] == `PORT_FREHD_HI)
      return is_out ? svc_frehd_out : svc_frehd_in;
    return is_out ? svc_trs_io_out : svc_trs_io_in;
  endfunction

  // one byte per cs_n frame, sck phases of 4 clocks, msb first
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] sh;
    sh = tx;
    rx = 8'h00;
    cs_n = 1'b0;
    repeat (4) next_cycle();
    for (int i = 0; i < 8; i++) begin
      mosi = sh[7];
      sh = {sh[6:0], 1'b0};
      repeat (4) next_cycle();
      if (i > 0)
        rx = {rx[6:0], miso};  // bit put out on the previous fall
      sck = 1'b1;
      repeat (4) next_cycle();
      sck = 1'b0;
    end
    repeat (4) next_cycle();
    rx = {rx[6:0], miso};
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (4) next_cycle();
    check_value(8'(miso), 8'h00, "miso with cs_n high");
  endtask

  // command byte, then a filler byte that carries the reply back
  task automatic esp_query(input logic [7:0] code, output logic [7:0] reply);
    logic [7:0] unused;
    spi_byte(code, unused);
    spi_byte(8'hff, reply);
  endtask

  task automatic esp_write(input logic [7:0] code, input logic [7:0] param);
    logic [7:0] unused;
    spi_byte(code, unused);
    spi_byte(param, unused);
  endtask

  // Z80 IN or OUT with the strobe held 8 cycles, ESP side served when hit
  task automatic io_access(input logic is_out, input logic [7:0] port, input logic [7:0] data);
    logic hit, drive_m, read_m;
    int   cnt;
    hit = esp_port(port);
    read_m = ~is_out;
    drive_m = hit & read_m;
    a = port;
    d_in = data;
    ioreq_n = 1'b0;
    if (is_out)
      out_n = 1'b0;
    else
      in_n = 1'b0;
    for (cnt = 0; cnt < 8; cnt++)
      next_cycle();
    check_value(8'(drive_en), 8'(drive_m), "drive_en");
    check_value(8'(esp_sel_in), 8'(drive_m), "esp_sel_in");
    check_value(8'(dir), 8'(read_m), "dir");
    check_value(d_out, drive_m ? trs_data_m : 8'h00, "d_out");
    check_value(8'(req), 8'(hit), "req during access");
    check_value(8'(bus_wait), 8'(hit), "wait during access");
    if (hit)
      check_value(8'(esp_s), 8'(service_for(port, is_out)), "esp_s");
    ioreq_n = 1'b1;
    in_n = 1'b1;
    out_n = 1'b1;
    if (hit) begin
      while (req && cnt < 60) begin
        next_cycle();
        cnt++;
      end
      check_value(8'(req), 8'h00, "req at cycle 60");
      check_value(8'(bus_wait), 8'h01, "wait before done");
      done = 1'b1;
      cnt = 0;
      while (bus_wait && cnt < 5) begin
        next_cycle();
        cnt++;
      end
      check_value(8'(bus_wait), 8'h00, "wait 5 cycles after done");
      done = 1'b0;
    end
    repeat (4) next_cycle();
    if (is_out && port == `PORT_CASS)
      cass_m = data[1:0];
    if (port == `PORT_TRS_IO)
      int_req_m = 1'b0;  // any 1fh access acknowledges
    check_value(8'(cass), 8'(cass_m), "cass");
    check_value(8'(int_req), 8'(int_req_m), "int_req");
  endtask

  initial begin
    logic [7:0] x, p, reply;
    {rst, cs_n, in_n, out_n, ioreq_n} = 5'b11111;
    {sck, mosi, done} = 3'b000;
    a = 8'h00;
    d_in = 8'h00;
    random_byte(x);
    conf = x[3:0];
    {trs_data_m, led_m, int_req_m, cass_m} = '0;
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;

    esp_query(cmd_get_cookie, reply);
    check_value(reply, `TRS_COOKIE, "get_cookie reply");
    esp_query(cmd_get_version, reply);
    check_value(reply, 8'h03, "get_version reply");
    esp_query(cmd_get_config, reply);
    check_value(reply, 8'(conf), "get_config reply");

    repeat (4) begin
      random_byte(a);
      random_byte(d_in);
      esp_query(cmd_abus_read, reply);
      check_value(reply, a, "abus_read reply");
      esp_query(cmd_dbus_read, reply);
      check_value(reply, d_in, "dbus_read reply");
    end

    repeat (6) begin
      random_byte(x);
      esp_write(cmd_dbus_write, x);
      trs_data_m = x;
      random_byte(p);
      p = p[0] ? `PORT_TRS_IO : {`PORT_FREHD_HI, p[7:4]};
      io_access(1'b0, p, 8'h00);
      random_byte(p);
      if (esp_port(p))
        p = p ^ 8'h20;  // step off the ESP ports
      io_access(1'b0, p, 8'h00);
      io_access(1'b1, p[0] ? `PORT_TRS_IO : {`PORT_FREHD_HI, p[3:0]}, x);
    end

    repeat (3) begin
      random_byte(x);
      esp_write(cmd_set_led, x);
      led_m = x[2:0];
      check_value(8'(led), 8'(led_m), "led");
      spi_byte(cmd_data_ready, reply);
      int_req_m = 1'b1;
      check_value(8'(int_req), 8'(int_req_m), "int_req after data_ready");
      io_access(x[7], `PORT_TRS_IO, x);
    end

    repeat (4) begin
      random_byte(x);
      io_access(1'b1, `PORT_CASS, x);
      random_byte(p);
      random_byte(x);
      if (p == `PORT_CASS)
        p = 8'h00;
      io_access(1'b1, p, x);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: test/trs_io_assert.sv
`timescale 1ns/1ns

`include "trs_io_params.svh"

module trs_io_assert (
  input logic clk,
  input logic rst,
  input logic req,
  input logic bus_wait,
  input logic done_rise,
  input logic cmd_valid
);

  logic [5:0] req_len;  // cycles req has been high so far

  always_ff @(posedge clk) begin
    if (rst)
      req_len <= 6'd0;
    else if (req)
      req_len <= req_len + 6'd1;
    else
      req_len <= 6'd0;
  end

  a_req_len: assert property (@(posedge clk) disable iff (rst)
    req |-> req_len < `REQ_HOLD_CYCLES)
    else $error("req pulse longer than the hold time");

  a_req_wait: assert property (@(posedge clk) disable iff (rst) req |-> bus_wait)
    else $error("req high without wait");

  // parser hands over one command per strobe
  a_cmd_single: assert property (@(posedge clk) disable iff (rst) cmd_valid |=> !cmd_valid)
    else $error("cmd_valid high two cycles in a row");

  a_wait_release: assert property (@(posedge clk) disable iff (rst)
    $fell(bus_wait) |-> $past(done_rise))
    else $error("wait released without a done rise");

endmodule
